/* compile.f */
src/game_pkg.sv
src/max7219_pkg.sv
src/player_position.sv
src/background_scroll.sv
src/game_control.sv
src/max7219_driver.sv
src/led_game_top.sv
verification/tb_clock_gen.sv
verification/led_game_asserts.sv
verification/tb_led_game.sv

/* run.sh */
#!/bin/sh
# Build and run the LED game testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_led_game \
	-f compile.f \
	-Mdir obj_dir \
	-o tb_led_game_sim

out=$(./obj_dir/tb_led_game_sim 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Result: PASSED"

/* src/background_scroll.sv */
// Scrolling background rows
`timescale 1ns/1ps
`default_nettype none

module background_scroll
	import game_pkg::*;
#(
	parameter int step_ticks = STEP_TICKS
) (
	input  logic   clock_50,
	input  logic   arst_n,
	input  logic   run,
	input  logic   restart,
	output image_t rows
);

	localparam int CNT_W = $clog2(step_ticks);

	logic [CNT_W-1:0] tick_cnt;
	logic             step;

	// Prescaler wrap marks one scroll step
	assign step = (tick_cnt == CNT_W'(step_ticks - 1));

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			rows     <= BG_INIT;
			tick_cnt <= '0;
		end else if (restart) begin
			rows     <= BG_INIT;
			tick_cnt <= '0;
		end else if (run) begin
			if (step) begin
				tick_cnt <= '0;
				// Every row moves one down, top row refills empty
				rows <= image_t'(rows >> MATRIX_COLS);
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* src/game_control.sv */
// Game state machine and image merge
`timescale 1ns/1ps
`default_nettype none

module game_control
	import game_pkg::*;
(
	input  logic     clock_50,
	input  logic     arst_n,
	input  buttons_t buttons,
	input  col_t     col,
	input  image_t   rows,
	output logic     run,
	output logic     restart,
	output logic     left,
	output logic     right,
	output image_t   image,
	output logic     game_over
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUNNING,
		ST_OVER
	} state_t;

	state_t state;
	logic   hit;

	// Background pixel on the player's spot
	assign hit = rows[0][col];

	assign run       = (state == ST_RUNNING) && !hit;
	assign restart   = buttons.start && (state != ST_RUNNING);
	assign game_over = (state == ST_OVER);

	// A lone strobe moves, start or the opposite strobe cancels it
	assign left  = buttons.left && !buttons.right && !buttons.start;
	assign right = buttons.right && !buttons.left && !buttons.start;

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
		end else if (restart) begin
			state <= ST_RUNNING;
		end else if (state == ST_RUNNING && hit) begin
			state <= ST_OVER;
		end
	end

	// Player dot drawn over the bottom background row
	always_comb begin
		image         = rows;
		image[0][col] = 1'b1;
	end

endmodule

`default_nettype wire

/* src/game_pkg.sv */
// Game geometry and constants
`default_nettype none

package game_pkg;

	// Matrix geometry
	localparam int MATRIX_ROWS = 8;
	localparam int MATRIX_COLS = 8;

	// One matrix row, bit k lights column k
	typedef logic [MATRIX_COLS-1:0] row_t;

	typedef logic [$clog2(MATRIX_COLS)-1:0] col_t;

	// Full picture, index 0 is the bottom row
	typedef row_t [MATRIX_ROWS-1:0] image_t;

	// One-cycle button strobes
	typedef struct packed {
		logic start;
		logic left;
		logic right;
	} buttons_t;

	// Clock cycles between two scroll steps
	localparam int STEP_TICKS = 64;

	localparam col_t START_COL = 3'd4;

	// Two bars on columns 5 to 7, in rows 2 and 4
	localparam image_t BG_INIT = 64'h0000_00E0_00E0_0000;

endpackage

`default_nettype wire

/* src/led_game_top.sv */
// LED matrix game top level
`timescale 1ns/1ps
`default_nettype none

module led_game_top
	import game_pkg::*;
	import max7219_pkg::*;
(
	input  logic     clock_50,
	input  logic     arst_n,
	input  buttons_t buttons,
	output serial_t  matrix,
	output logic     game_over
);

	logic   run;
	logic   restart;
	logic   left;
	logic   right;
	col_t   col;
	image_t rows;
	image_t image;

	//############################################################################
	// Game logic
	//############################################################################

	game_control i_game_control (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.buttons  (buttons),
		.col      (col),
		.rows     (rows),
		.run      (run),
		.restart  (restart),
		.left     (left),
		.right    (right),
		.image    (image),
		.game_over(game_over)
	);

	player_position i_player_position (
		.clock_50(clock_50),
		.arst_n  (arst_n),
		.run     (run),
		.restart (restart),
		.left    (left),
		.right   (right),
		.col     (col)
	);

	background_scroll #(
		.step_ticks(STEP_TICKS)
	) i_background_scroll (
		.clock_50(clock_50),
		.arst_n  (arst_n),
		.run     (run),
		.restart (restart),
		.rows    (rows)
	);

	// Display side
	max7219_driver i_max7219_driver (
		.clock_50(clock_50),
		.arst_n  (arst_n),
		.image   (image),
		.matrix  (matrix)
	);

endmodule

`default_nettype wire

/* src/max7219_driver.sv */
// MAX7219 serial driver
`timescale 1ns/1ps
`default_nettype none

module max7219_driver
	import game_pkg::*;
	import max7219_pkg::*;
(
	input  logic    clock_50,
	input  logic    arst_n,
	input  image_t  image,
	output serial_t matrix
);

	localparam logic [3:0] FIRST_ROW  = 4'(INIT_FRAMES);
	localparam logic [3:0] LAST_PHASE = 4'(INIT_FRAMES + MATRIX_ROWS - 1);

	logic [3:0]                       phase;
	logic [$clog2(FRAME_BITS)-1:0]    bit_cnt;
	logic [FRAME_BITS-1:0]            shreg;
	logic [$clog2(MATRIX_ROWS)-1:0]   row_idx;
	image_t                           image_q;
	row_t                             row_data;
	frame_t                           next_frame;

	//############################################################################
	// Frame builder
	//############################################################################

	assign row_idx = 3'(phase - FIRST_ROW);

	// First row of a pass comes straight from the input, it is latched then
	assign row_data = (phase == FIRST_ROW) ? image[0] : image_q[row_idx];

	always_comb begin
		next_frame.unused = '0;
		case (phase)
			4'd0: begin
				next_frame.addr = REG_SHUTDOWN;
				next_frame.data = 8'd1;
			end
			4'd1: begin
				next_frame.addr = REG_DISPLAY_TEST;
				next_frame.data = 8'd0;
			end
			4'd2: begin
				next_frame.addr = REG_SCAN_LIMIT;
				next_frame.data = 8'd7;
			end
			4'd3: begin
				next_frame.addr = REG_DECODE;
				next_frame.data = 8'd0;
			end
			4'd4: begin
				next_frame.addr = REG_INTENSITY;
				next_frame.data = {4'h0, INTENSITY};
			end
			default: begin
				next_frame.addr = REG_DIGIT0 + {1'b0, row_idx};
				next_frame.data = row_data;
			end
		endcase
	end

	//############################################################################
	// Bit-serial shifter
	//############################################################################

	// Gap cycle starts a frame, then two cycles per bit
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			matrix  <= '{din: 1'b0, cs_n: 1'b1, sclk: 1'b1};
			phase   <= '0;
			bit_cnt <= '0;
		end else if (matrix.cs_n) begin
			matrix  <= '{din: next_frame[FRAME_BITS-1], cs_n: 1'b0, sclk: 1'b0};
			bit_cnt <= ($clog2(FRAME_BITS))'(FRAME_BITS - 1);
		end else if (!matrix.sclk) begin
			matrix.sclk <= 1'b1;
		end else if (bit_cnt == '0) begin
			// Last bit done, release chip select for one cycle
			matrix <= '{din: 1'b0, cs_n: 1'b1, sclk: 1'b1};
			phase  <= (phase == LAST_PHASE) ? FIRST_ROW : phase + 1'b1;
		end else begin
			matrix.din  <= shreg[FRAME_BITS-1];
			matrix.sclk <= 1'b0;
			bit_cnt     <= bit_cnt - 1'b1;
		end
	end

	// Shift data and the latched picture
	always_ff @(posedge clock_50) begin
		if (matrix.cs_n) begin
			shreg <= {next_frame[FRAME_BITS-2:0], 1'b0};
			if (phase == FIRST_ROW) begin
				image_q <= image;
			end
		end else if (matrix.sclk && bit_cnt != '0) begin
			shreg <= shreg << 1;
		end
	end

endmodule

`default_nettype wire

/* src/max7219_pkg.sv */
// MAX7219 serial definitions
`default_nettype none

package max7219_pkg;

	// One 16-bit command word, sent MSB first
	typedef struct packed {
		logic [3:0] unused;
		logic [3:0] addr;
		logic [7:0] data;
	} frame_t;

	// Serial pins toward the controller
	typedef struct packed {
		logic din;
		logic cs_n;
		logic sclk;
	} serial_t;

	// Controller register map
	localparam logic [3:0] REG_DIGIT0       = 4'h1;
	localparam logic [3:0] REG_DECODE       = 4'h9;
	localparam logic [3:0] REG_INTENSITY    = 4'hA;
	localparam logic [3:0] REG_SCAN_LIMIT   = 4'hB;
	localparam logic [3:0] REG_SHUTDOWN     = 4'hC;
	localparam logic [3:0] REG_DISPLAY_TEST = 4'hF;

	localparam logic [3:0] INTENSITY = 4'hA;

	localparam int FRAME_BITS  = 16;
	localparam int INIT_FRAMES = 5;

endpackage

`default_nettype wire

/* src/player_position.sv */
// Player column register
`timescale 1ns/1ps
`default_nettype none

module player_position
	import game_pkg::*;
(
	input  logic clock_50,
	input  logic arst_n,
	input  logic run,
	input  logic restart,
	input  logic left,
	input  logic right,
	output col_t col
);

	// Strobes arrive already qualified, only one of them at a time
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			col <= START_COL;
		end else if (restart) begin
			col <= START_COL;
		end else if (run) begin
			// Column wraps naturally at the register width
			if (left) begin
				col <= col + 1'b1;
			end else if (right) begin
				col <= col - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* verification/led_game_asserts.sv */
// Serial link and game-over assertions
`timescale 1ns/1ps
`default_nettype none

module led_game_asserts
	import game_pkg::*;
	import max7219_pkg::*;
(
	input logic     clock_50,
	input logic     arst_n,
	input buttons_t buttons,
	input serial_t  matrix,
	input logic     game_over
);

	// Serial clock edges only inside a frame
	sclk_inside_frame: assert property (
		@(posedge clock_50) disable iff (!arst_n)
		$rose(matrix.sclk) |-> !matrix.cs_n
	) else $error("sclk rose while cs_n was high");

	cs_n_idle_in_reset: assert property (
		@(posedge clock_50)
		!arst_n |-> matrix.cs_n
	) else $error("cs_n low during reset");

	// Only a start strobe ends the game-over level
	game_over_held: assert property (
		@(posedge clock_50) disable iff (!arst_n)
		(game_over && !buttons.start) |=> game_over
	) else $error("game_over dropped without a start strobe");

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int period_ns    = 10,
	parameter int reset_cycles = 2
) (
	output logic clock_50,
	output logic arst_n
);

	initial begin
		clock_50 = 1'b0;
		forever #(period_ns / 2) clock_50 = ~clock_50;
	end

	// Reset falls just after time zero and is released just after a rising edge
	initial begin
		arst_n = 1'b1;
		#1;
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clock_50);
		#1;
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* verification/tb_led_game.sv */
// LED matrix game testbench
`timescale 1ns/1ps
`default_nettype none

module tb_led_game
	import game_pkg::*;
	import max7219_pkg::*;
();

	localparam int IDLE_CYCLES = 800;
	localparam int PASSES      = 40;
	localparam int NUM_FRAMES  = INIT_FRAMES + PASSES * MATRIX_ROWS;
	localparam int WAIT_LIMIT  = 100;

	localparam int PIN_RESET = 0;
	localparam int PIN_CS_N  = 1;
	localparam int PIN_SCLK  = 2;

	localparam logic [1:0] MODEL_IDLE    = 2'd0;
	localparam logic [1:0] MODEL_RUNNING = 2'd1;
	localparam logic [1:0] MODEL_OVER    = 2'd2;

	logic     clock_50;
	logic     arst_n;
	buttons_t buttons;
	serial_t  matrix;
	logic     game_over;

	// Cycle model of the game
	logic [1:0]  m_state;
	col_t        m_col;
	int          m_cnt;
	image_t      m_rows;
	image_t      img_before;
	logic [31:0] lfsr_state;

	int   frame_errors   = 0;
	int   flag_errors    = 0;
	int   timeout_errors = 0;
	int   games_lost     = 0;
	logic timed_out      = 1'b0;

	tb_clock_gen #(
		.period_ns   (10),
		.reset_cycles(2)
	) i_clock_gen (
		.clock_50(clock_50),
		.arst_n  (arst_n)
	);

	led_game_top i_dut (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.buttons  (buttons),
		.matrix   (matrix),
		.game_over(game_over)
	);

	bind led_game_top led_game_asserts i_asserts (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.buttons  (buttons),
		.matrix   (matrix),
		.game_over(game_over)
	);

	//############################################################################
	// Random source and model
	//############################################################################

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0]) begin
			next = next ^ 32'h8020_0003;
		end
		return next;
	endfunction

	task automatic draw_bits(input int count, output logic [7:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			value      = {value[6:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	function automatic image_t merged_image(input image_t rows, input col_t col);
		image_t img;
		img         = rows;
		img[0][col] = 1'b1;
		return img;
	endfunction

	task automatic advance_model(input buttons_t b);
		logic hit;
		logic go;
		logic lone_left;
		logic lone_right;
		hit        = m_rows[0][m_col];
		go         = (m_state == MODEL_RUNNING) && !hit;
		lone_left  = b.left && !b.right && !b.start;
		lone_right = b.right && !b.left && !b.start;
		if (b.start && m_state != MODEL_RUNNING) begin
			m_state = MODEL_RUNNING;
			m_rows  = BG_INIT;
			m_cnt   = 0;
			m_col   = START_COL;
		end else begin
			if (m_state == MODEL_RUNNING && hit) begin
				m_state = MODEL_OVER;
				games_lost++;
			end
			if (go) begin
				if (lone_left) begin
					m_col = m_col + 3'd1;
				end else if (lone_right) begin
					m_col = m_col - 3'd1;
				end
				// Rows move down one place and the top row comes in empty
				if (m_cnt == STEP_TICKS - 1) begin
					m_cnt  = 0;
					m_rows = {row_t'(0), m_rows[MATRIX_ROWS-1:1]};
				end else begin
					m_cnt++;
				end
			end
		end
	endtask

	task automatic drive_buttons(input logic allow_start);
		logic [7:0] v;
		buttons_t   next;
		draw_bits(3, v);
		next.left = (v[2:0] == 3'd0);
		draw_bits(4, v);
		next.right = (v[3:0] == 4'd0);
		// Quick restart after a lost game and rare start otherwise
		if (m_state == MODEL_OVER) begin
			draw_bits(4, v);
			next.start = (v[3:0] == 4'd0);
		end else begin
			draw_bits(8, v);
			next.start = allow_start && (v == 8'd0);
		end
		buttons = next;
	endtask

	//############################################################################
	// Checks and waits
	//############################################################################

	function automatic frame_t init_frame(input int index);
		case (index)
			0:       return {4'h0, REG_SHUTDOWN, 8'd1};
			1:       return {4'h0, REG_DISPLAY_TEST, 8'd0};
			2:       return {4'h0, REG_SCAN_LIMIT, 8'd7};
			3:       return {4'h0, REG_DECODE, 8'd0};
			default: return {4'h0, REG_INTENSITY, 4'h0, INTENSITY};
		endcase
	endfunction

	task automatic check_frame(input frame_t got, input frame_t exp, input int index);
		if (got !== exp) begin
			frame_errors++;
			$display("[ERROR] %0t matrix frame %0d: expected %h, got %h",
				$time, index, exp, got);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp);
		if (got !== exp) begin
			flag_errors++;
			$display("[ERROR] %0t game_over: expected %b, got %b", $time, exp, got);
		end
	endtask

	function automatic logic pin_level(input int pin);
		case (pin)
			PIN_RESET: return arst_n;
			PIN_CS_N:  return matrix.cs_n;
			default:   return matrix.sclk;
		endcase
	endfunction

	// Steps on falling clock edges where the serial pins are settled
	task automatic wait_pin(input int pin, input logic level);
		int    waited;
		string name;
		waited = 0;
		if (pin == PIN_RESET) begin
			name = "arst_n";
		end else if (pin == PIN_CS_N) begin
			name = "cs_n";
		end else begin
			name = "sclk";
		end
		while (!timed_out && pin_level(pin) !== level) begin
			if (waited == WAIT_LIMIT) begin
				timed_out = 1'b1;
				timeout_errors++;
				$display("Timeout at %0t: %s did not reach %b within %0d cycles",
					$time, name, level, WAIT_LIMIT);
			end else begin
				@(negedge clock_50);
				waited++;
			end
		end
	endtask

	//############################################################################
	// Stimulus and frame decoder
	//############################################################################

	initial begin : model_and_stimulus
		int cycle;
		cycle      = 0;
		lfsr_state = 32'd72633;
		buttons    = '0;
		m_state    = MODEL_IDLE;
		m_col      = START_COL;
		m_cnt      = 0;
		m_rows     = BG_INIT;
		img_before = merged_image(BG_INIT, START_COL);
		forever begin
			@(posedge clock_50);
			img_before = merged_image(m_rows, m_col);
			if (arst_n) begin
				advance_model(buttons);
				cycle++;
			end
			#1;
			check_flag(game_over, m_state == MODEL_OVER);
			drive_buttons(cycle >= IDLE_CYCLES);
		end
	end

	initial begin : frame_decoder
		frame_t                got;
		frame_t                exp;
		image_t                shown;
		logic [FRAME_BITS-1:0] bits;
		logic [2:0]            row_sel;
		logic [3:0]            addr;
		int                    n;
		int                    b;
		$timeformat(-9, 1, " ns", 0);
		shown   = '0;
		row_sel = '0;
		wait_pin(PIN_RESET, 1'b0);
		wait_pin(PIN_RESET, 1'b1);
		n = 0;
		while (n < NUM_FRAMES && !timed_out) begin
			wait_pin(PIN_CS_N, 1'b0);
			// A pass shows the picture from just before its first chip select edge
			if (n >= INIT_FRAMES) begin
				row_sel = 3'((n - INIT_FRAMES) % MATRIX_ROWS);
				if (row_sel == 3'd0) begin
					shown = img_before;
				end
			end
			bits = '0;
			b    = 0;
			while (b < FRAME_BITS && !timed_out) begin
				wait_pin(PIN_SCLK, 1'b0);
				wait_pin(PIN_SCLK, 1'b1);
				bits = {bits[FRAME_BITS-2:0], matrix.din};
				b++;
			end
			wait_pin(PIN_CS_N, 1'b1);
			got = frame_t'(bits);
			if (n < INIT_FRAMES) begin
				exp = init_frame(n);
			end else begin
				addr = REG_DIGIT0 + {1'b0, row_sel};
				exp  = {4'h0, addr, shown[row_sel]};
			end
			if (!timed_out) begin
				check_frame(got, exp, n);
			end
			n++;
		end
		if (games_lost == 0) begin
			flag_errors++;
			$display("No game ever reached game over, so the hit path went untested");
		end
		$display("Frames decoded %0d, games lost %0d", n, games_lost);
		$display("Errors: frame %0d, game_over %0d, timeout %0d",
			frame_errors, flag_errors, timeout_errors);
		if (frame_errors + flag_errors + timeout_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
